// ==== filelist.f ====
src/dn_msg_pkg.sv
src/dn_lut_pkg.sv
src/dn_lut_if.sv
src/sym_dn_rank.sv
src/sym_dn_lut_out.sv
src/sym_dn_top.sv
verif/sym_dn_props.sv
verif/sym_dn_tb.sv

// ==== verif/sym_dn_tb.sv ====
`timescale 1ns/1ps

module sym_dn_tb
	import dn_msg_pkg::*, dn_lut_pkg::*;
();

	localparam logic [31:0] lfsr_seed   = 32'hb4600e81;
	localparam int          drain_limit = 8;

	// One read request {transpose, y0, y1}
	typedef struct packed {
		logic             te;
		logic [msg_w-1:0] y0;
		logic [msg_w-1:0] y1;
	} rd_req_t;

	logic read_clk, rst, read_addr_offset;
	logic transpose_en_a, transpose_en_b, t_c_a, t_c_b;
	logic [msg_w-1:0] y0_a, y1_a, y0_b, y1_b;
	logic lut_in_bank0, lut_in_bank1, write_addr_offset, we;
	logic [page_w-1:0] page_write_addr;

	// Shadow copy of both banks
	logic shadow [n_banks][bank_depth];
	// Expected results in flight {chk_a, exp_a, chk_b, exp_b}
	logic [3:0] exp_q [$];
	int pend;
	logic [31:0] lfsr;
	// Reset level and write {we, offset, page, bit0, bit1} for the next edge
	logic nx_rst;
	logic [page_w+3:0] nx_wr;

	sym_dn_top #(.fold_mode(FOLD_FULL)) i_dut (.*);

	always #20 read_clk = ~read_clk;

	//////////////////////////////
	// Stimulus and reference model
	//////////////////////////////

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic rd_req_t rand_req();
		logic [31:0] v;
		v = rand_bits($bits(rd_req_t));
		return v[$bits(rd_req_t)-1:0];
	endfunction

	// Folded index {page, bank}
	function automatic logic [lut_idx_w-1:0] fold_addr(input rd_req_t r);
		logic fs;
		logic [mag_w-1:0] mag;
		fs  = r.y0[msg_w-1] ^ r.te;
		// Negative y0 mirrors the magnitude
		mag = r.y0[msg_w-1] ? ~r.y0[mag_w-1:0] : r.y0[mag_w-1:0];
		return {mag, fs ? ~r.y1 : r.y1};
	endfunction

	// Shadow entry unfolded by the folded sign
	function automatic logic expect_tc(input rd_req_t r, input logic off);
		logic [lut_idx_w-1:0] a;
		a = fold_addr(r);
		return shadow[a[0]][{off, a[lut_idx_w-1:1]}] ^ r.y0[msg_w-1] ^ r.te;
	endfunction

	task automatic check(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s, expected %b, got %b",
				$time, what, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// Drive one cycle and check the read issued two cycles back
	task automatic step(input rd_req_t a, input rd_req_t b, input logic off,
		input logic chk_a, input logic chk_b);
		logic [3:0] e;
		@(posedge read_clk);
		rst <= nx_rst;
		{transpose_en_a, y0_a, y1_a} <= a;
		{transpose_en_b, y0_b, y1_b} <= b;
		read_addr_offset <= off;
		{we, write_addr_offset, page_write_addr, lut_in_bank0, lut_in_bank1} <= nx_wr;
		// Write lands before this read captures its entry
		if (nx_wr[page_w+3]) begin
			shadow[0][nx_wr[page_w+2:2]] = nx_wr[1];
			shadow[1][nx_wr[page_w+2:2]] = nx_wr[0];
		end
		nx_wr = '0;
		exp_q.push_back({chk_a, chk_a && expect_tc(a, off), chk_b, chk_b && expect_tc(b, off)});
		if (chk_a || chk_b)
			pend++;
		@(negedge read_clk);
		if (exp_q.size() > 2) begin
			e = exp_q.pop_front();
			if (e[3] || e[1])
				pend--;
			if (e[3])
				check(t_c_a, e[2], "port A hard decision");
			if (e[1])
				check(t_c_b, e[0], "port B hard decision");
		end
	endtask

	// Idle until no checked read is in flight
	task automatic drain();
		int n;
		n = 0;
		while (pend > 0) begin
			if (n == drain_limit) begin
				$display("Timeout: checked reads still in flight after %0d idle cycles", n);
				$display("TEST RESULT: FAIL");
				$fatal(1);
			end
			step('0, '0, 1'b0, 1'b0, 1'b0);
			n++;
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic reset_outputs();
		// Zero entry 0, idle reads land there
		nx_wr = {1'b1, {(page_w + 3){1'b0}}};
		for (int i = 0; i < 12; i++) begin
			nx_rst = (i < 9);
			step('0, '0, 1'b0, 1'b0, 1'b0);
			check(t_c_a, 1'b0, "port A output in or just after reset");
			check(t_c_b, 1'b0, "port B output in or just after reset");
		end
	endtask

	task automatic full_sweep_port_a();
		logic [31:0] v;
		// Both banks, both offsets
		for (int i = 0; i < bank_depth; i++) begin
			v = rand_bits(2);
			nx_wr = {1'b1, i[page_w:0], v[1:0]};
			step('0, '0, 1'b0, 1'b0, 1'b0);
		end
		// Every y0, y1 pair, offset 0, no transpose
		for (int c = 0; c < 256; c++)
			step({1'b0, c[7:0]}, '0, 1'b0, 1'b1, 1'b0);
		drain();
	endtask

	task automatic transpose_both_ports();
		rd_req_t a;
		rd_req_t b;
		logic [31:0] v;
		for (int i = 0; i < 48; i++) begin
			a = rand_req();
			b = rand_req();
			// Keep the ports on different messages
			if (b.y0 == a.y0 && b.y1 == a.y1)
				b.y1 = ~a.y1;
			v = rand_bits(1);
			step(a, b, v[0], 1'b1, 1'b1);
		end
		drain();
	endtask

	task automatic offset_halves();
		logic [31:0] v;
		for (int k = 0; k < 8; k++) begin
			v = rand_bits(page_w + 2);
			// Same page, complementary bits per half
			nx_wr = {1'b1, 1'b0, v[page_w+1:0]};
			step('0, '0, 1'b0, 1'b0, 1'b0);
			nx_wr = {1'b1, 1'b1, v[page_w+1:2], ~v[1:0]};
			step('0, '0, 1'b0, 1'b0, 1'b0);
			// Positive y0 and no transpose map straight onto the page
			for (int h = 0; h < 4; h++)
				step({2'b00, v[page_w+1:2], h[1]}, '0, h[0], 1'b1, 1'b0);
		end
		drain();
	endtask

	task automatic back_to_back_stream();
		// Offset flips every cycle
		for (int i = 0; i < 64; i++)
			step(rand_req(), rand_req(), i[0], 1'b1, 1'b1);
		drain();
	endtask

	task automatic rewrite_entry();
		rd_req_t r;
		logic [lut_idx_w-1:0] a;
		r = rand_req();
		a = fold_addr(r);
		// Captured on the write edge, so still the old bit
		step(r, '0, 1'b1, 1'b1, 1'b0);
		// Invert the entry in its own bank only
		nx_wr = {1'b1, 1'b1, a[lut_idx_w-1:1],
			shadow[0][{1'b1, a[lut_idx_w-1:1]}] ^ ~a[0],
			shadow[1][{1'b1, a[lut_idx_w-1:1]}] ^ a[0]};
		// Loaded on the write edge, sees the new bit
		step(r, '0, 1'b1, 1'b1, 1'b0);
		step(r, '0, 1'b1, 1'b1, 1'b0);
		drain();
	endtask

	initial begin
		read_clk = 1'b0;
		rst = 1'b1;
		{transpose_en_a, y0_a, y1_a, transpose_en_b, y0_b, y1_b} = '0;
		{read_addr_offset, we, write_addr_offset, page_write_addr} = '0;
		{lut_in_bank0, lut_in_bank1} = '0;
		lfsr = lfsr_seed;
		nx_rst = 1'b1;
		nx_wr = '0;
		pend = 0;
		reset_outputs();
		full_sweep_port_a();
		transpose_both_ports();
		offset_halves();
		back_to_back_stream();
		rewrite_entry();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verif/sym_dn_props.sv ====
`timescale 1ns/1ps

module sym_dn_props
	import dn_lut_pkg::*;
(
	input logic              read_clk,
	input logic              rst,
	input logic              we,
	input logic [page_w-1:0] page_write_addr,
	input logic              write_addr_offset,
	input logic              lut_in_bank0,
	input logic              lut_in_bank1,
	input logic              t_c_a,
	input logic              t_c_b,
	// Stage 0 addresses on both read links
	input logic [page_w-1:0] rd_a_page,
	input logic [page_w-1:0] rd_b_page,
	input logic [1:0]        rd_bank,
	input logic [1:0]        rd_offset
);

	// Write fields driven whenever we is high
	a_write_known: assert property (@(posedge read_clk)
		we |-> !$isunknown({page_write_addr, write_addr_offset,
			lut_in_bank0, lut_in_bank1}))
		else $error("write address or data unknown while we is high");

	// Pipeline cleared by reset
	a_reset_clears: assert property (@(posedge read_clk) rst |=> !t_c_a && !t_c_b)
		else $error("hard decision not low after reset");

	// Stage 0 always holds a real address
	a_read_known: assert property (@(posedge read_clk) disable iff (rst)
		!$isunknown({rd_a_page, rd_b_page, rd_bank, rd_offset}))
		else $error("read address unknown outside reset");

endmodule

bind sym_dn_top sym_dn_props i_props (
	.read_clk          (read_clk),
	.rst               (rst),
	.we                (we),
	.page_write_addr   (page_write_addr),
	.write_addr_offset (write_addr_offset),
	.lut_in_bank0      (lut_in_bank0),
	.lut_in_bank1      (lut_in_bank1),
	.t_c_a             (t_c_a),
	.t_c_b             (t_c_b),
	.rd_a_page         (rd_a.page),
	.rd_b_page         (rd_b.page),
	.rd_bank           ({rd_b.bank, rd_a.bank}),
	.rd_offset         ({rd_b.offset, rd_a.offset})
);

// ==== src/sym_dn_top.sv ====
`timescale 1ns/1ps

module sym_dn_top
	import dn_msg_pkg::*, dn_lut_pkg::*;
#(
	parameter fold_mode_e fold_mode = FOLD_FULL
) (
	input  logic              read_clk,
	input  logic              rst,
	// Read port A
	input  logic              transpose_en_a,
	input  logic [msg_w-1:0]  y0_a,
	input  logic [msg_w-1:0]  y1_a,
	output logic              t_c_a,
	// Read port B
	input  logic              transpose_en_b,
	input  logic [msg_w-1:0]  y0_b,
	input  logic [msg_w-1:0]  y1_b,
	output logic              t_c_b,
	input  logic              read_addr_offset,
	// Table load
	input  logic              lut_in_bank0,
	input  logic              lut_in_bank1,
	input  logic [page_w-1:0] page_write_addr,
	input  logic              write_addr_offset,
	input  logic              we
);

	// Datapath to memory links
	lut_rd_if rd_a ();
	lut_rd_if rd_b ();
	lut_wr_if wr ();

	// Write port straight from the pins
	assign wr.we        = we;
	assign wr.page      = page_write_addr;
	assign wr.offset    = write_addr_offset;
	assign wr.bit_bank0 = lut_in_bank0;
	assign wr.bit_bank1 = lut_in_bank1;

	sym_dn_lut_out #(
		.fold_mode (fold_mode)
	) i_lut_out (
		.read_clk         (read_clk),
		.rst              (rst),
		.transpose_en_a   (transpose_en_a),
		.y0_a             (y0_a),
		.y1_a             (y1_a),
		.t_c_a            (t_c_a),
		.transpose_en_b   (transpose_en_b),
		.y0_b             (y0_b),
		.y1_b             (y1_b),
		.t_c_b            (t_c_b),
		.read_addr_offset (read_addr_offset),
		.rd_a             (rd_a.requester),
		.rd_b             (rd_b.requester)
	);

	// Port A on rd_0, port B on rd_1
	sym_dn_rank #(
		.page_w (page_w)
	) i_rank (
		.read_clk (read_clk),
		.rd_0     (rd_a.responder),
		.rd_1     (rd_b.responder),
		.wr       (wr.sink)
	);

endmodule

// ==== src/sym_dn_lut_out.sv ====
`timescale 1ns/1ps

module sym_dn_lut_out
	import dn_msg_pkg::*, dn_lut_pkg::*;
#(
	parameter fold_mode_e fold_mode = FOLD_FULL
) (
	input  logic             read_clk,
	input  logic             rst,
	// Port A messages
	input  logic             transpose_en_a,
	input  logic [msg_w-1:0] y0_a,
	input  logic [msg_w-1:0] y1_a,
	output logic             t_c_a,
	// Port B messages
	input  logic             transpose_en_b,
	input  logic [msg_w-1:0] y0_b,
	input  logic [msg_w-1:0] y1_b,
	output logic             t_c_b,
	// Page half, shared by both ports
	input  logic             read_addr_offset,
	// Memory read ports
	lut_rd_if.requester      rd_a,
	lut_rd_if.requester      rd_b
);

	//////////////////////////////
	// Symmetry fold
	//////////////////////////////

	// Folded index from one message pair
	// fsign is the folded sign of y0
	function automatic logic [lut_idx_w-1:0] fold_idx(
		input logic [msg_w-1:0] y0,
		input logic [msg_w-1:0] y1,
		input logic             fsign
	);
		logic [mag_w-1:0] mag;
		logic [msg_w-1:0] y1_f;
		mag = y0[mag_w-1:0];
		// Reflect magnitude by the raw sign
		if (fold_mode == FOLD_FULL) begin
			mag = mag ^ {mag_w{y0[msg_w-1]}};
		end
		// Negative half mirrors y1
		y1_f = fsign ? ~y1 : y1;
		return {mag, y1_f};
	endfunction

	// Folded sign per port
	logic sign_a;
	logic sign_b;
	// Folded index per port
	logic [lut_idx_w-1:0] idx_a;
	logic [lut_idx_w-1:0] idx_b;

	assign sign_a = y0_a[msg_w-1] ^ transpose_en_a;
	assign sign_b = y0_b[msg_w-1] ^ transpose_en_b;
	assign idx_a  = fold_idx(y0_a, y1_a, sign_a);
	assign idx_b  = fold_idx(y0_b, y1_b, sign_b);

	//////////////////////////////
	// Stage 0
	//////////////////////////////

	logic [lut_idx_w-1:0] idx_s0_a;
	logic [lut_idx_w-1:0] idx_s0_b;
	logic                 sign_s0_a;
	logic                 sign_s0_b;
	logic                 offset_s0;

	always_ff @(posedge read_clk) begin
		if (rst) begin
			idx_s0_a  <= '0;
			idx_s0_b  <= '0;
			sign_s0_a <= 1'b0;
			sign_s0_b <= 1'b0;
			offset_s0 <= 1'b0;
		end else begin
			idx_s0_a  <= idx_a;
			idx_s0_b  <= idx_b;
			sign_s0_a <= sign_a;
			sign_s0_b <= sign_b;
			offset_s0 <= read_addr_offset;
		end
	end

	// Address mapping
	// Upper bits are the page, bit 0 the bank
	assign rd_a.page   = idx_s0_a[lut_idx_w-1 -: page_w];
	assign rd_a.bank   = idx_s0_a[0];
	assign rd_a.offset = offset_s0;
	assign rd_b.page   = idx_s0_b[lut_idx_w-1 -: page_w];
	assign rd_b.bank   = idx_s0_b[0];
	assign rd_b.offset = offset_s0;

	//////////////////////////////
	// Stage 1
	//////////////////////////////

	// Memory entry and sign, aligned
	logic data_s1_a;
	logic data_s1_b;
	logic sign_s1_a;
	logic sign_s1_b;

	always_ff @(posedge read_clk) begin
		if (rst) begin
			data_s1_a <= 1'b0;
			data_s1_b <= 1'b0;
			sign_s1_a <= 1'b0;
			sign_s1_b <= 1'b0;
		end else begin
			data_s1_a <= rd_a.data;
			data_s1_b <= rd_b.data;
			sign_s1_a <= sign_s0_a;
			sign_s1_b <= sign_s0_b;
		end
	end

	// Hard decision, unfold by the sign
	assign t_c_a = data_s1_a ^ sign_s1_a;
	assign t_c_b = data_s1_b ^ sign_s1_b;

endmodule

// ==== src/sym_dn_rank.sv ====
`timescale 1ns/1ps

module sym_dn_rank
	import dn_lut_pkg::*;
#(
	parameter int page_w = dn_lut_pkg::page_w
) (
	input logic           read_clk,
	// Two independent read ports
	lut_rd_if.responder   rd_0,
	lut_rd_if.responder   rd_1,
	// One write port for both banks
	lut_wr_if.sink        wr
);

	// Entry index is offset bit above the page
	localparam int idx_w = page_w + 1;

	//////////////////////////////
	// Storage
	//////////////////////////////

	// Bank 0 and bank 1, 1 bit per entry
	// Contents are undefined until loaded
	logic bank_mem [n_banks][bank_depth];

	// Entry indices per port
	logic [idx_w-1:0] rd0_idx;
	logic [idx_w-1:0] rd1_idx;
	logic [idx_w-1:0] wr_idx;

	assign rd0_idx = {rd_0.offset, rd_0.page};
	assign rd1_idx = {rd_1.offset, rd_1.page};
	assign wr_idx  = {wr.offset, wr.page};

	//////////////////////////////
	// Write
	//////////////////////////////

	// Both banks at the same entry in one edge
	// Visible to reads right after this edge
	always_ff @(posedge read_clk) begin
		if (wr.we) begin
			bank_mem[0][wr_idx] <= wr.bit_bank0;
			bank_mem[1][wr_idx] <= wr.bit_bank1;
		end
	end

	//////////////////////////////
	// Read
	//////////////////////////////

	// Asynchronous reads
	// Bank bit picks the bank, index picks the entry
	assign rd_0.data = bank_mem[rd_0.bank][rd0_idx];
	assign rd_1.data = bank_mem[rd_1.bank][rd1_idx];

	// Ports never conflict, a read only looks at the array
	// Same entry on both ports is fine

endmodule

// ==== src/dn_lut_if.sv ====
`timescale 1ns/1ps

//////////////////////////////
// Read port of the lookup memory
//////////////////////////////

interface lut_rd_if
	import dn_lut_pkg::*;
();

	// Address from the datapath stage 0
	logic              bank;
	logic [page_w-1:0] page;
	logic              offset;
	// Entry, combinational from the address
	logic              data;

	modport requester (
		output bank,
		output page,
		output offset,
		input  data
	);

	modport responder (
		input  bank,
		input  page,
		input  offset,
		output data
	);

endinterface

//////////////////////////////
// Shared write port, both banks at once
//////////////////////////////

interface lut_wr_if
	import dn_lut_pkg::*;
();

	logic              we;
	logic [page_w-1:0] page;
	logic              offset;
	// One bit per bank, same entry
	logic              bit_bank0;
	logic              bit_bank1;

	modport source (
		output we,
		output page,
		output offset,
		output bit_bank0,
		output bit_bank1
	);

	modport sink (
		input we,
		input page,
		input offset,
		input bit_bank0,
		input bit_bank1
	);

endinterface

// ==== src/dn_lut_pkg.sv ====
package dn_lut_pkg;

	//////////////////////////////
	// Lookup table geometry
	//////////////////////////////

	// Page address into one bank
	localparam int page_w = 6;

	// Two banks share one address space
	// Selected by the lowest bit of the folded index
	localparam int n_banks = 2;

	// Entries per bank
	// Index is {offset, page}, so one offset bit doubles the pages
	localparam int bank_depth = 128;

	// Folded message index
	// {y0 folded magnitude, y1 after folding}
	// Upper bits give the page, bit 0 the bank
	localparam int lut_idx_w = 7;

	// Half the full table is stored thanks to the symmetry fold
	// Full table would need the y0 sign bit as well

	// Layout per bank
	//   idx[6]   offset
	//   idx[5:0] page

endpackage

// ==== src/dn_msg_pkg.sv ====
package dn_msg_pkg;

	//////////////////////////////
	// Channel message format
	//////////////////////////////

	// One sign-magnitude channel message
	// Top bit is the sign, the rest is the magnitude
	localparam int msg_w = 4;

	// Magnitude part of y0 after folding
	// Same bits as the message minus the sign
	localparam int mag_w = 3;

	//////////////////////////////
	// Symmetry fold variants
	//////////////////////////////

	// How the y0 magnitude is treated by the fold
	// FOLD_FULL reflects the magnitude around the sign
	// FOLD_SIGN_ONLY keeps the magnitude as received
	typedef enum logic {
		FOLD_FULL      = 1'b0,
		FOLD_SIGN_ONLY = 1'b1
	} fold_mode_e;

	// In both variants y1 flips with the folded sign
	// and the folded sign is y0 sign ^ transpose enable

endpackage
